/* common/router_pkg.sv */
package router_pkg;

    localparam int num_ports = 4;                       // Physical MAC ports
    localparam int route_entries = 16;                  // LPM table depth

    typedef logic [2*num_ports-1:0] port_mask_t;        // One-hot, even MAC, odd CPU
    typedef logic [1:0]             port_index_t;       // Physical port number k
    typedef logic [47:0]            mac_addr_t;
    typedef logic [31:0]            ip_addr_t;
    typedef logic [7:0]             ttl_t;
    typedef logic [15:0]            ethertype_t;
    typedef logic [3:0]             route_index_t;
    typedef logic [7:0]             cfg_addr_t;
    typedef logic [31:0]            cfg_data_t;
    typedef logic [15:0]            count_t;

    localparam ethertype_t ethertype_ipv4 = 16'h0800;
    localparam logic [3:0] ip_version_4 = 4'd4;
    localparam port_mask_t cpu_port_mask = 8'hAA;       // Odd bits are CPU ports

    // Config address map, word addressed
    localparam cfg_addr_t cfg_mac_base = 8'h00;         // Low word at 2k, high word at 2k+1
    localparam cfg_addr_t cfg_own_ip = 8'h08;
    localparam cfg_addr_t cfg_route_base = 8'h40;       // Four words per entry
    localparam int cfg_mac_words = 2 * num_ports;
    localparam int cfg_route_words = 4 * route_entries;
    localparam int route_valid_bit = 8;                 // In the port word

    typedef struct packed {
        logic      wr;                                  // One-cycle write strobe
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_write_t;

    typedef struct packed {
        mac_addr_t  dst_mac;
        ethertype_t ethertype;
        logic [3:0] ip_version;
        ttl_t       ttl;
        ip_addr_t   dst_ip;
        port_mask_t src_port;
        port_mask_t dst_port;
        ip_addr_t   next_hop;
    } pkt_desc_t;

    typedef enum logic [2:0] {
        v_forward,                                      // No objection from the checker
        v_cpu_bypass,
        v_wrong_mac,
        v_non_ip,
        v_bad_version,
        v_dest_hit,
        v_bad_ttl,
        v_lpm_miss
    } verdict_e;

    typedef struct packed {
        logic        valid;
        verdict_e    verdict;
        port_index_t src_index;
        pkt_desc_t   desc;
    } check_result_t;

    typedef struct packed {
        logic       hit;
        port_mask_t port;
        ip_addr_t   next_hop;                           // Zero means deliver directly
    } route_result_t;

    typedef struct packed {
        count_t forwarded;
        count_t to_cpu;
        count_t dropped;
    } stat_counts_t;

endpackage

/* header_check/header_check.sv */
module header_check
    import router_pkg::*;
(
    input  logic          AXI_ACLK,
    input  logic          AXI_RESETN,
    input  cfg_write_t    cfg,
    input  logic          in_valid,
    input  pkt_desc_t     in_desc,
    input  logic          advance,
    output check_result_t check_result
);

    mac_addr_t   own_mac [num_ports];       // One MAC per physical port
    ip_addr_t    own_ip;
    cfg_addr_t   mac_off;                   // Offset into the MAC window
    port_index_t mac_sel;
    port_index_t src_index;
    logic        from_cpu;
    logic        mac_ok;
    verdict_e    verdict;

    assign mac_off = cfg.addr - cfg_mac_base;
    assign mac_sel = mac_off[2:1];

    // Config writes, low word first in the map
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN) begin
            for (int k = 0; k < num_ports; k++) begin
                own_mac[k] <= '0;
            end
            own_ip <= '0;
        end else if (cfg.wr) begin
            if (cfg.addr >= cfg_mac_base && cfg.addr < cfg_mac_base + cfg_mac_words) begin
                if (mac_off[0])
                    own_mac[mac_sel][47:32] <= cfg.data[15:0];  // Upper 16 bits only
                else
                    own_mac[mac_sel][31:0] <= cfg.data;
            end
            if (cfg.addr == cfg_own_ip)
                own_ip <= cfg.data;
        end
    end

    // Physical port number of the one-hot source
    always_comb begin
        src_index = '0;
        for (int k = 0; k < num_ports; k++) begin
            if (in_desc.src_port[2*k] || in_desc.src_port[2*k+1])
                src_index = port_index_t'(k);
        end
    end

    assign from_cpu = |(in_desc.src_port & cpu_port_mask);
    assign mac_ok = (in_desc.dst_mac == own_mac[src_index]) || (&in_desc.dst_mac);  // Own or bcast

    // First match wins
    always_comb begin
        if (from_cpu)
            verdict = v_cpu_bypass;
        else if (!mac_ok)
            verdict = v_wrong_mac;
        else if (in_desc.ethertype != ethertype_ipv4)
            verdict = v_non_ip;
        else if (in_desc.ip_version != ip_version_4)
            verdict = v_bad_version;
        else if (in_desc.dst_ip == own_ip)
            verdict = v_dest_hit;                   // Addressed to the router itself
        else if (in_desc.ttl <= ttl_t'(1))
            verdict = v_bad_ttl;                    // Would expire here
        else
            verdict = v_forward;
    end

    // Stage-1 register, held while the output stalls
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN) begin
            check_result.valid <= 1'b0;
        end else if (advance) begin
            check_result <= '{valid: in_valid, verdict: verdict,
                              src_index: src_index, desc: in_desc};
        end
    end

    // Source must name exactly one port when the stream hands over a packet
    a_src_onehot: assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        in_valid && advance |-> $onehot(in_desc.src_port));

endmodule

/* route_lookup/route_lookup.sv */
module route_lookup
    import router_pkg::*;
(
    input  logic          AXI_ACLK,
    input  logic          AXI_RESETN,
    input  cfg_write_t    cfg,
    input  pkt_desc_t     in_desc,
    input  logic          advance,
    output route_result_t route_result
);

    // Table columns
    ip_addr_t   route_prefix   [route_entries];
    ip_addr_t   route_mask     [route_entries];
    ip_addr_t   route_next_hop [route_entries];
    port_mask_t route_port     [route_entries];
    logic [route_entries-1:0] route_valid;

    cfg_addr_t    route_off;
    route_index_t wr_index;
    logic [1:0]   wr_word;
    logic         route_wr;
    logic         hit;
    route_index_t hit_index;

    assign route_off = cfg.addr - cfg_route_base;
    assign wr_index  = route_index_t'(route_off >> 2);
    assign wr_word   = route_off[1:0];
    assign route_wr  = cfg.wr && cfg.addr >= cfg_route_base
                       && cfg.addr < cfg_route_base + cfg_route_words;

    // Entry payload, written word by word
    always_ff @(posedge AXI_ACLK) begin
        if (route_wr) begin
            case (wr_word)
                2'd0: route_prefix[wr_index] <= cfg.data;
                2'd1: route_mask[wr_index] <= cfg.data;
                2'd2: route_next_hop[wr_index] <= cfg.data;
                2'd3: route_port[wr_index] <= cfg.data[7:0];   // Port mask in low byte
                default: ;
            endcase
        end
    end

    // Valid flags live in the port word
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN) begin
            route_valid <= '0;                      // Empty table
        end else if (route_wr && wr_word == 2'd3) begin
            route_valid[wr_index] <= cfg.data[route_valid_bit];
        end
    end

    // Priority search
    // Walk from the top so the lowest matching index ends up in hit_index
    // Software orders entries longest prefix first
    always_comb begin
        hit = 1'b0;
        hit_index = '0;
        for (int i = route_entries - 1; i >= 0; i--) begin
            if (route_valid[i]
                && (in_desc.dst_ip & route_mask[i]) == route_prefix[i]) begin
                hit = 1'b1;
                hit_index = route_index_t'(i);
            end
        end
    end

    // Stage-1 register, in step with header_check
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN) begin
            route_result.hit <= 1'b0;
        end else if (advance) begin
            route_result <= '{hit: hit,
                              port: route_port[hit_index],
                              next_hop: route_next_hop[hit_index]};
        end
    end

    // A matched route must point at exactly one MAC port
    // Checks the table contents loaded earlier over cfg
    a_hit_port_mac: assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        route_result.hit |-> $onehot(route_result.port)
                             && (route_result.port & cpu_port_mask) == '0);

endmodule

/* router_lookup.f */
+incdir+verif
common/router_pkg.sv
header_check/header_check.sv
route_lookup/route_lookup.sv
source/forward_decision.sv
source/router_lookup_top.sv
verif/router_lookup_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator and run; the exit status is the test result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f router_lookup.f --top-module router_lookup_tb -o router_lookup_sim \
    && ./obj_dir/router_lookup_sim \
    || { echo "router_lookup simulation failed"; exit 1; }
exit 0

/* source/forward_decision.sv */
module forward_decision
    import router_pkg::*;
(
    input  logic          AXI_ACLK,
    input  logic          AXI_RESETN,
    input  check_result_t check_result,
    input  route_result_t route_result,
    input  logic          out_ready,
    output logic          advance,
    output logic          out_valid,
    output pkt_desc_t     out_desc,
    output stat_counts_t  counts
);

    port_mask_t mac_port;                   // Bit 2k of the source port
    port_mask_t cpu_port;                   // Bit 2k+1 of the source port
    pkt_desc_t  next_desc;
    logic       emit;                       // Produces an output beat
    logic       cnt_fwd;
    logic       cnt_cpu;
    logic       take;

    // Stall only when a held beat is refused
    assign advance = !(out_valid && !out_ready);
    assign take = check_result.valid && advance;

    assign mac_port = port_mask_t'(1) << {check_result.src_index, 1'b0};
    assign cpu_port = port_mask_t'(2) << {check_result.src_index, 1'b0};

    always_comb begin
        next_desc = check_result.desc;
        emit = 1'b0;
        cnt_fwd = 1'b0;
        cnt_cpu = 1'b0;
        case (check_result.verdict)
            v_forward: begin
                if (route_result.hit) begin
                    next_desc.dst_port = route_result.port;
                    next_desc.ttl = check_result.desc.ttl - 1'b1;
                    next_desc.next_hop = (route_result.next_hop == '0)
                                         ? check_result.desc.dst_ip    // Directly attached
                                         : route_result.next_hop;
                    emit = 1'b1;
                    cnt_fwd = 1'b1;
                end                                 // LPM miss drops
            end
            v_cpu_bypass: begin
                next_desc.dst_port = mac_port;      // CPU k out of MAC k
                emit = 1'b1;
                cnt_fwd = 1'b1;
            end
            v_non_ip, v_dest_hit, v_bad_ttl: begin
                next_desc.dst_port = cpu_port;      // Punt to the paired CPU port
                emit = 1'b1;
                cnt_cpu = 1'b1;
            end
            default: ;                              // Wrong MAC, bad version
        endcase
    end

    // Output register
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= check_result.valid && emit;
            out_desc <= next_desc;
        end
    end

    // Exactly one counter per accepted result
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN) begin
            counts <= '0;
        end else if (take) begin
            if (cnt_fwd)
                counts.forwarded <= counts.forwarded + 1'b1;
            else if (cnt_cpu)
                counts.to_cpu <= counts.to_cpu + 1'b1;
            else
                counts.dropped <= counts.dropped + 1'b1;
        end
    end

    // Held beat must not change under back-pressure
    a_out_stable: assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        out_valid && !out_ready |=> out_valid && $stable(out_desc));

endmodule

/* source/router_lookup_top.sv */
module router_lookup_top
    import router_pkg::*;
(
    input  logic         AXI_ACLK,
    input  logic         AXI_RESETN,

    input  cfg_write_t   cfg,               // Config write strobe

    input  logic         in_valid,
    input  pkt_desc_t    in_desc,
    output logic         in_ready,

    output logic         out_valid,
    output pkt_desc_t    out_desc,
    input  logic         out_ready,

    output stat_counts_t counts
);

    logic          advance;                 // Pipeline enable from the output stage
    check_result_t check_result;
    route_result_t route_result;

    assign in_ready = advance;              // Both stage-1 blocks move together

    // Header classification, runs beside the lookup
    header_check u_header_check (
        .AXI_ACLK     (AXI_ACLK),
        .AXI_RESETN   (AXI_RESETN),
        .cfg          (cfg),
        .in_valid     (in_valid),
        .in_desc      (in_desc),
        .advance      (advance),
        .check_result (check_result)
    );

    // Longest-prefix match on dst_ip
    route_lookup u_route_lookup (
        .AXI_ACLK     (AXI_ACLK),
        .AXI_RESETN   (AXI_RESETN),
        .cfg          (cfg),
        .in_desc      (in_desc),
        .advance      (advance),
        .route_result (route_result)
    );

    forward_decision u_forward_decision (
        .AXI_ACLK     (AXI_ACLK),
        .AXI_RESETN   (AXI_RESETN),
        .check_result (check_result),
        .route_result (route_result),
        .out_ready    (out_ready),
        .advance      (advance),
        .out_valid    (out_valid),
        .out_desc     (out_desc),
        .counts       (counts)
    );

endmodule

/* verif/router_lookup_vectors.svh */
`ifndef router_lookup_vectors_svh
`define router_lookup_vectors_svh

// One row per packet
// Inputs are dst_mac, ethertype, version, ttl, dst_ip and src_port
// Expected values are dst_port, ttl, next_hop and the counter class
task automatic load_vectors();
    // Routed traffic
    add_row(port_mac(0), ethertype_ipv4, 4'd4, 8'd64, 32'h0A01_0203, 8'h01,
            8'h04, 8'd63, 32'h0A00_0001, c_fwd);         // Entry 0 beats 1 and 2
    add_row(port_mac(1), ethertype_ipv4, 4'd4, 8'd64, 32'h0A01_FF01, 8'h04,
            8'h01, 8'd63, 32'h0A00_0002, c_fwd);         // Falls to the /16
    add_row(port_mac(2), ethertype_ipv4, 4'd4, 8'd10, 32'h0A7F_0001, 8'h10,
            8'h10, 8'd9, 32'h0A7F_0001, c_fwd);          // Zero next hop, own dst_ip
    add_row(port_mac(3), ethertype_ipv4, 4'd4, 8'd2, 32'hAC1F_0001, 8'h40,
            8'h40, 8'd1, 32'hAC10_0001, c_fwd);          // Lowest ttl still routed
    add_row(48'hFFFF_FFFF_FFFF, ethertype_ipv4, 4'd4, 8'd5, 32'hC0A8_0577, 8'h01,
            8'h10, 8'd4, 32'hC0A8_0502, c_fwd);          // Broadcast accepted
    // Exceptions to the CPU
    add_row(port_mac(1), 16'h0806, 4'd4, 8'd64, 32'h0000_0000, 8'h04,
            8'h08, 8'd64, 32'h0000_0000, c_cpu);         // ARP
    add_row(port_mac(2), ethertype_ipv4, 4'd4, 8'd64, router_ip, 8'h10,
            8'h20, 8'd64, 32'h0000_0000, c_cpu);         // Own IP
    add_row(port_mac(3), ethertype_ipv4, 4'd4, 8'd1, 32'h0A01_0203, 8'h40,
            8'h80, 8'd1, 32'h0000_0000, c_cpu);          // TTL 1
    add_row(port_mac(0), ethertype_ipv4, 4'd4, 8'd0, 32'h0A01_0203, 8'h01,
            8'h02, 8'd0, 32'h0000_0000, c_cpu);
    // CPU bypass
    add_row(48'h0000_0000_0000, ethertype_ipv4, 4'd4, 8'd1, 32'h0A01_0203, 8'h08,
            8'h04, 8'd1, 32'h0000_0000, c_fwd);
    add_row(port_mac(0), 16'h86DD, 4'd6, 8'd33, 32'h0808_0808, 8'h80,
            8'h40, 8'd33, 32'h0000_0000, c_fwd);
    // Drops mixed with survivors
    add_row(port_mac(1), ethertype_ipv4, 4'd4, 8'd64, 32'h0A01_0203, 8'h01,
            8'h00, 8'd0, 32'h0000_0000, c_drop);         // Another port's MAC
    add_row(port_mac(1), ethertype_ipv4, 4'd6, 8'd64, 32'h0A01_0203, 8'h04,
            8'h00, 8'd0, 32'h0000_0000, c_drop);         // Version 6
    add_row(port_mac(2), ethertype_ipv4, 4'd4, 8'd64, 32'h0808_0808, 8'h10,
            8'h00, 8'd0, 32'h0000_0000, c_drop);         // No route
    add_row(port_mac(3), ethertype_ipv4, 4'd4, 8'd128, 32'h1400_0005, 8'h40,
            8'h01, 8'd127, 32'h1400_0009, c_fwd);
    add_row(port_mac(2), ethertype_ipv4, 4'd4, 8'd255, 32'h0A01_02FF, 8'h10,
            8'h04, 8'd254, 32'h0A00_0001, c_fwd);
    add_row(48'hFFFF_FFFF_FFFE, ethertype_ipv4, 4'd4, 8'd64, 32'h0A01_0203, 8'h40,
            8'h00, 8'd0, 32'h0000_0000, c_drop);         // Near broadcast
    add_row(48'hFFFF_FFFF_FFFF, 16'h86DD, 4'd6, 8'd64, 32'h0000_0000, 8'h04,
            8'h08, 8'd64, 32'h0000_0000, c_cpu);
    add_row(port_mac(0), ethertype_ipv4, 4'd4, 8'd64, 32'hAC2F_0000, 8'h01,
            8'h00, 8'd0, 32'h0000_0000, c_drop);         // Outside the /12
    add_row(port_mac(0), ethertype_ipv4, 4'd4, 8'd3, 32'h0A01_0000, 8'h01,
            8'h01, 8'd2, 32'h0A00_0002, c_fwd);          // Misses the /24
endtask

`endif

/* verif/router_lookup_tb.sv */
module router_lookup_tb
    import router_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [1:0] c_fwd = 2'd0;                 // Counter classes
    localparam logic [1:0] c_cpu = 2'd1;
    localparam logic [1:0] c_drop = 2'd2;
    localparam int stall_limit = 200;                    // Cycles per accept
    localparam int drain_limit = 200;
    localparam ip_addr_t router_ip = 32'hC0A8_0001;

    typedef struct packed {
        pkt_desc_t  desc;                                // Driven descriptor
        port_mask_t exp_port;
        ttl_t       exp_ttl;
        ip_addr_t   exp_hop;
        logic [1:0] cls;
    } vec_row_t;

    logic         AXI_ACLK;
    logic         AXI_RESETN;
    cfg_write_t   cfg;
    logic         in_valid;
    pkt_desc_t    in_desc;
    logic         in_ready;
    logic         out_valid;
    pkt_desc_t    out_desc;
    logic         out_ready;
    stat_counts_t counts;

    vec_row_t    rows[$];
    vec_row_t    exp_q[$];                               // Beats still owed, in order
    logic [31:0] lfsr = 32'h052cbc7b;

    router_lookup_top DUT (
        .AXI_ACLK   (AXI_ACLK),
        .AXI_RESETN (AXI_RESETN),
        .cfg        (cfg),
        .in_valid   (in_valid),
        .in_desc    (in_desc),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_desc   (out_desc),
        .out_ready  (out_ready),
        .counts     (counts)
    );

    always #50 AXI_ACLK = ~AXI_ACLK;                     // 100 ns period

    function automatic mac_addr_t port_mac(int k);
        return 48'h0200_0000_0010 + mac_addr_t'(k);      // Locally administered
    endfunction

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic stop_with_failure(string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp)
            stop_with_failure($sformatf("** Error: %s is %h, expected %h", name, got, exp));
    endtask

    task automatic add_row(mac_addr_t mac, ethertype_t etype, logic [3:0] ver, ttl_t ttl,
                           ip_addr_t dst_ip, port_mask_t src, port_mask_t exp_port,
                           ttl_t exp_ttl, ip_addr_t exp_hop, logic [1:0] cls);
        vec_row_t row;
        row.desc = '{dst_mac: mac, ethertype: etype, ip_version: ver, ttl: ttl,
                     dst_ip: dst_ip, src_port: src, dst_port: '0, next_hop: '0};
        row.exp_port = exp_port;
        row.exp_ttl = exp_ttl;
        row.exp_hop = exp_hop;
        row.cls = cls;
        rows.push_back(row);
    endtask

    `include "router_lookup_vectors.svh"

    task automatic cfg_write(cfg_addr_t addr, cfg_data_t data);
        @(negedge AXI_ACLK);
        cfg = '{wr: 1'b1, addr: addr, data: data};       // Back to back strobes
    endtask

    task automatic route_write(int i, ip_addr_t prefix, ip_addr_t mask, ip_addr_t hop,
                               port_mask_t port);
        cfg_addr_t base;
        base = cfg_route_base + cfg_addr_t'(4 * i);
        cfg_write(base, prefix);
        cfg_write(base + 8'd1, mask);
        cfg_write(base + 8'd2, hop);
        cfg_write(base + 8'd3, {23'd0, 1'b1, port});     // Valid in bit 8
    endtask

    task automatic configure();
        mac_addr_t mac;
        for (int k = 0; k < num_ports; k++) begin
            mac = port_mac(k);
            cfg_write(cfg_mac_base + cfg_addr_t'(2 * k), mac[31:0]);
            cfg_write(cfg_mac_base + cfg_addr_t'(2 * k + 1), {16'd0, mac[47:32]});
        end
        cfg_write(cfg_own_ip, router_ip);
        // Longest prefix first
        route_write(0, 32'h0A01_0200, 32'hFFFF_FF00, 32'h0A00_0001, 8'h04);
        route_write(1, 32'h0A01_0000, 32'hFFFF_0000, 32'h0A00_0002, 8'h01);
        route_write(2, 32'h0A00_0000, 32'hFF00_0000, 32'h0000_0000, 8'h10);  // Attached
        route_write(3, 32'hAC10_0000, 32'hFFF0_0000, 32'hAC10_0001, 8'h40);
        route_write(4, 32'hC0A8_0500, 32'hFFFF_FF00, 32'hC0A8_0502, 8'h10);
        route_write(5, 32'h1400_0000, 32'hFF00_0000, 32'h1400_0009, 8'h01);
        @(negedge AXI_ACLK);
        cfg.wr = 1'b0;
    endtask

    task automatic check_beat(vec_row_t row);
        compare_value("out_desc.dst_mac", out_desc.dst_mac, row.desc.dst_mac);
        compare_value("out_desc.ethertype", out_desc.ethertype, row.desc.ethertype);
        compare_value("out_desc.ip_version", out_desc.ip_version, row.desc.ip_version);
        compare_value("out_desc.dst_ip", out_desc.dst_ip, row.desc.dst_ip);
        compare_value("out_desc.src_port", out_desc.src_port, row.desc.src_port);
        compare_value("out_desc.dst_port", out_desc.dst_port, row.exp_port);
        compare_value("out_desc.ttl", out_desc.ttl, row.exp_ttl);
        compare_value("out_desc.next_hop", out_desc.next_hop, row.exp_hop);
    endtask

    // Drive on the falling edge, then look at the settled handshakes
    task automatic drive_cycle(logic valid, pkt_desc_t desc, output logic accepted);
        logic ready;
        @(negedge AXI_ACLK);
        random_bit(ready);
        out_ready = ready;
        in_valid = valid;
        in_desc = desc;                                  // Held while stalled
        #1;
        accepted = in_valid && in_ready;
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0)
                stop_with_failure("Output beat appeared with no packet outstanding");
            check_beat(exp_q.pop_front());
        end
    endtask

    function automatic int count_total();
        return int'(counts.forwarded) + int'(counts.to_cpu) + int'(counts.dropped);
    endfunction

    initial begin
        int   fwd_tally;
        int   cpu_tally;
        int   drop_tally;
        int   waited;
        logic accepted;
        fwd_tally = 0;
        cpu_tally = 0;
        drop_tally = 0;
        AXI_ACLK = 1'b0;
        AXI_RESETN = 1'b0;
        cfg = '0;
        in_valid = 1'b0;
        in_desc = '0;
        out_ready = 1'b0;
        load_vectors();
        repeat (16) @(posedge AXI_ACLK);
        @(negedge AXI_ACLK);
        AXI_RESETN = 1'b1;
        #1;
        compare_value("in_ready", in_ready, 1);
        compare_value("out_valid", out_valid, 0);
        compare_value("counts", counts, 0);
        configure();
        for (int r = 0; r < rows.size(); r++) begin
            waited = 0;
            accepted = 1'b0;
            while (!accepted && waited < stall_limit) begin
                drive_cycle(1'b1, rows[r].desc, accepted);
                waited++;
            end
            if (!accepted)
                stop_with_failure($sformatf("Timeout: row %0d never accepted", r));
            case (rows[r].cls)
                c_fwd: fwd_tally++;
                c_cpu: cpu_tally++;
                default: drop_tally++;
            endcase
            if (rows[r].cls != c_drop)
                exp_q.push_back(rows[r]);
        end
        // Drain until every beat is out and every packet counted
        waited = 0;
        while ((exp_q.size() != 0 || count_total() != rows.size()) && waited < drain_limit) begin
            drive_cycle(1'b0, '0, accepted);
            waited++;
        end
        if (exp_q.size() != 0 || count_total() != rows.size())
            stop_with_failure("Timeout: pipeline did not drain after the last packet");
        compare_value("counts.forwarded", counts.forwarded, fwd_tally);
        compare_value("counts.to_cpu", counts.to_cpu, cpu_tally);
        compare_value("counts.dropped", counts.dropped, drop_tally);
        $display("TEST PASS");
        $finish;
    end

endmodule
